// ==== flist.f ====
exec_pkg.sv
stage_if.sv
cmd_intake.sv
regfile.sv
shifter.sv
alu.sv
exec_datapath.sv
result_out.sv
exec_top.sv
tb_exec_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
    --top-module tb_exec_top \
    -f flist.f \
    -o tb_exec_top

./obj_dir/tb_exec_top | tee sim.log

if grep -q "Simulation failed" sim.log; then
    echo "run failed, details in sim.log"
    exit 1
fi

echo "run finished, details in sim.log"

// ==== tb_exec_top.sv ====
`timescale 1ns/100ps

module tb_exec_top;

    localparam int MAX_ROWS     = 200;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_RANDOM   = 60;
    localparam int GRP_RANDOM   = 5;

    logic             clk = 1'b0;
    logic             rst;
    logic             cmd_valid;
    exec_pkg::cmd_t   cmd;
    logic             cmd_ready;
    logic [31:0]      res_data;
    logic [3:0]       res_rd;
    logic             res_valid;
    logic             res_wrote;
    exec_pkg::flags_t res_flags;
    logic             res_ready;

    // command table and the expected result of each row
    exec_pkg::cmd_t   tbl_cmd   [MAX_ROWS];
    int               tbl_group [MAX_ROWS];
    logic [31:0]      exp_data  [MAX_ROWS];
    logic [3:0]       exp_rd    [MAX_ROWS];
    logic             exp_wrote [MAX_ROWS];
    exec_pkg::flags_t exp_flags [MAX_ROWS];
    string            grp_name  [6];

    int   n_rows;
    int   build_grp;
    int   res_idx;
    int   err_count;
    int   grp_results;
    int   grp_errors;
    logic table_ready;
    logic random_ready;

    always #5 clk = ~clk;

    exec_top #(.XLEN(32)) dut_i (
        .clk              (clk),
        .rst              (rst),
        .cmd_valid        (cmd_valid),
        .cmd_op           (cmd.op),
        .cmd_rd           (cmd.rd),
        .cmd_rn           (cmd.rn),
        .cmd_rm           (cmd.rm),
        .cmd_rs           (cmd.rs),
        .cmd_shift_op     (cmd.shift_op),
        .cmd_shift_imm    (cmd.shift_imm),
        .cmd_shift_by_reg (cmd.shift_by_reg),
        .cmd_use_imm      (cmd.use_imm),
        .cmd_imm          (cmd.imm),
        .cmd_set_flags    (cmd.set_flags),
        .cmd_ready        (cmd_ready),
        .res_valid        (res_valid),
        .res_data         (res_data),
        .res_rd           (res_rd),
        .res_wrote        (res_wrote),
        .res_flags        (res_flags),
        .res_ready        (res_ready)
    );

    task automatic store_row(input exec_pkg::cmd_t row);
        tbl_cmd[n_rows]   = row;
        tbl_group[n_rows] = build_grp;
        n_rows++;
    endtask

    task automatic add_row(input exec_pkg::alu_op_t op, input int rd, input int rn,
                           input int rm, input int rs, input exec_pkg::shift_op_t sop,
                           input int amt, input logic by_reg, input logic use_imm,
                           input logic [31:0] imm, input logic sf);
        exec_pkg::cmd_t row;
        row.op           = op;
        row.rd           = 4'(rd);
        row.rn           = 4'(rn);
        row.rm           = 4'(rm);
        row.rs           = 4'(rs);
        row.shift_op     = sop;
        row.shift_imm    = 5'(amt);
        row.shift_by_reg = by_reg;
        row.use_imm      = use_imm;
        row.imm          = imm;
        row.set_flags    = sf;
        store_row(row);
    endtask

    task automatic add_imm(input exec_pkg::alu_op_t op, input int rd, input int rn,
                           input logic [31:0] imm, input logic sf);
        add_row(op, rd, rn, 0, 0, exec_pkg::SH_LSL, 0, 1'b0, 1'b1, imm, sf);
    endtask

    task automatic add_sh(input exec_pkg::alu_op_t op, input int rd, input int rn, input int rm,
                          input exec_pkg::shift_op_t sop, input int amt, input logic sf);
        add_row(op, rd, rn, rm, 0, sop, amt, 1'b0, 1'b0, 32'h0, sf);
    endtask

    // immediate amount 9 must be ignored in favour of Rs
    task automatic add_shr(input exec_pkg::alu_op_t op, input int rd, input int rn, input int rm,
                           input int rs, input exec_pkg::shift_op_t sop, input logic sf);
        add_row(op, rd, rn, rm, rs, sop, 9, 1'b1, 1'b0, 32'h0, sf);
    endtask

    task automatic build_table();
        exec_pkg::alu_op_t data_ops [6] = '{exec_pkg::OP_ADD, exec_pkg::OP_SUB,
            exec_pkg::OP_AND, exec_pkg::OP_ORR, exec_pkg::OP_EOR, exec_pkg::OP_MVN};
        exec_pkg::cmd_t    rnd;
        build_grp = 0;
        for (int i = 0; i < 16; i++)
            add_imm(exec_pkg::OP_MOV, i, 0, 32'h0f1e_2d3c + 32'h1111_1111 * i, 1'b0);
        for (int i = 0; i < 16; i++)
            add_sh(exec_pkg::OP_MOV, i, 0, i, exec_pkg::SH_LSL, 0, 1'b0);
        // r8 takes every result, r9..r14 hold negative values for ASR
        build_grp = 1;
        for (int k = 0; k < 6; k++) begin
            add_imm(data_ops[k], 8, k, 32'h0000_00ff << (4 * k), k[0]);
            for (int s = 0; s < 4; s++)
                add_sh(data_ops[k], 8, k, 14 - k, exec_pkg::shift_op_t'(2'(s)), 3 + 7 * s, k[0]);
            add_sh(data_ops[k], 8, k, 14 - k, exec_pkg::SH_ROR, 0, 1'b1);
        end
        // amounts 31, 0 and 4 hidden under junk upper bits
        build_grp = 2;
        add_imm(exec_pkg::OP_MOV, 13, 0, 32'h0000_003f, 1'b0);
        add_imm(exec_pkg::OP_MOV, 14, 0, 32'hffff_ff20, 1'b0);
        add_imm(exec_pkg::OP_MOV, 15, 0, 32'h0000_0104, 1'b0);
        for (int s = 0; s < 4; s++) begin
            add_shr(exec_pkg::OP_MOV, 9, 0, 12, 15, exec_pkg::shift_op_t'(2'(s)), 1'b1);
            add_shr(exec_pkg::OP_EOR, 10, 2, 12, 13, exec_pkg::shift_op_t'(2'(s)), 1'b1);
        end
        add_shr(exec_pkg::OP_MOV, 11, 0, 12, 14, exec_pkg::SH_LSR, 1'b1);
        build_grp = 3;
        add_imm(exec_pkg::OP_ADD, 1, 0, 32'h0000_0001, 1'b0);
        add_sh(exec_pkg::OP_ADD, 2, 1, 1, exec_pkg::SH_LSL, 1, 1'b0);
        add_sh(exec_pkg::OP_SUB, 3, 2, 0, exec_pkg::SH_LSL, 0, 1'b0);
        add_shr(exec_pkg::OP_MOV, 4, 0, 0, 3, exec_pkg::SH_ROR, 1'b0);
        add_sh(exec_pkg::OP_EOR, 4, 4, 4, exec_pkg::SH_ROR, 3, 1'b0);
        add_imm(exec_pkg::OP_ORR, 6, 4, 32'h8000_0000, 1'b1);
        add_sh(exec_pkg::OP_ADD, 6, 6, 6, exec_pkg::SH_LSL, 0, 1'b1);
        add_sh(exec_pkg::OP_ADD, 6, 6, 6, exec_pkg::SH_ASR, 2, 1'b1);
        // CMP writes nothing, so r7 comes from the register file
        add_sh(exec_pkg::OP_CMP, 7, 6, 6, exec_pkg::SH_LSL, 0, 1'b0);
        add_sh(exec_pkg::OP_MOV, 9, 0, 7, exec_pkg::SH_LSL, 0, 1'b0);
        build_grp = 4;
        add_imm(exec_pkg::OP_MOV, 0, 0, 32'h0, 1'b1);
        add_imm(exec_pkg::OP_MOV, 2, 0, 32'h7fff_ffff, 1'b0);
        add_imm(exec_pkg::OP_ADD, 3, 2, 32'h1, 1'b1);
        add_imm(exec_pkg::OP_MOV, 4, 0, 32'hffff_ffff, 1'b0);
        add_imm(exec_pkg::OP_ADD, 5, 4, 32'h1, 1'b1);
        add_imm(exec_pkg::OP_SUB, 6, 0, 32'h1, 1'b1);
        add_imm(exec_pkg::OP_AND, 7, 4, 32'h0, 1'b0);
        add_imm(exec_pkg::OP_CMP, 4, 2, 32'h8000_0000, 1'b0);
        add_sh(exec_pkg::OP_MOV, 9, 0, 4, exec_pkg::SH_LSL, 0, 1'b0);
        add_sh(exec_pkg::OP_MOV, 10, 0, 4, exec_pkg::SH_LSR, 1, 1'b1);
        add_sh(exec_pkg::OP_EOR, 11, 4, 4, exec_pkg::SH_LSL, 0, 1'b1);
        build_grp = GRP_RANDOM;
        for (int j = 0; j < NUM_RANDOM; j++) begin
            rnd.op           = exec_pkg::alu_op_t'(3'($urandom));
            rnd.rd           = 4'($urandom);
            rnd.rn           = 4'($urandom);
            rnd.rm           = 4'($urandom);
            rnd.rs           = 4'($urandom);
            rnd.shift_op     = exec_pkg::shift_op_t'(2'($urandom));
            rnd.shift_imm    = 5'($urandom);
            rnd.shift_by_reg = 1'($urandom);
            rnd.use_imm      = ($urandom_range(0, 3) == 0);
            rnd.imm          = $urandom;
            rnd.set_flags    = 1'($urandom);
            store_row(rnd);
        end
    endtask

    // returns {carry, value}
    function automatic logic [32:0] shift_ref(input logic [31:0] val,
                                              input exec_pkg::shift_op_t kind, input int n);
        logic [31:0] res;
        logic        c;
        if (n == 0) begin
            res = val;
            c   = 1'b0;
        end else begin
            case (kind)
                exec_pkg::SH_LSL: res = val << n;
                exec_pkg::SH_LSR: res = val >> n;
                exec_pkg::SH_ASR: res = $signed(val) >>> n;
                default:          res = (val >> n) | (val << (32 - n));
            endcase
            c = (kind == exec_pkg::SH_LSL) ? val[32 - n] : val[n - 1];
        end
        return {c, res};
    endfunction

    // sequential model over the whole table
    task automatic run_model();
        logic [31:0]      regs [16];
        exec_pkg::flags_t fl;
        exec_pkg::cmd_t   row;
        logic [31:0]      a;
        logic [31:0]      b;
        logic [31:0]      res;
        logic [32:0]      sh;
        logic [32:0]      wide;
        logic             c;
        logic             v;
        logic             arith;
        int               amt;
        fl = '0;
        for (int r = 0; r < 16; r++)
            regs[r] = 32'h0;
        for (int i = 0; i < n_rows; i++) begin
            row = tbl_cmd[i];
            a   = regs[row.rn];
            amt = row.shift_by_reg ? int'(regs[row.rs][4:0]) : int'(row.shift_imm);
            sh  = row.use_imm ? {1'b0, row.imm} : shift_ref(regs[row.rm], row.shift_op, amt);
            b   = sh[31:0];
            c   = sh[32];
            v   = fl.v;
            arith = 1'b1;
            case (row.op)
                exec_pkg::OP_ADD: begin
                    wide = {1'b0, a} + {1'b0, b};
                    res  = wide[31:0];
                    c    = wide[32];
                    v    = (a[31] == b[31]) && (res[31] != a[31]);
                end
                exec_pkg::OP_SUB, exec_pkg::OP_CMP: begin
                    res = a - b;
                    c   = (a >= b);
                    v   = (a[31] != b[31]) && (res[31] != a[31]);
                end
                default: begin
                    arith = 1'b0;
                    case (row.op)
                        exec_pkg::OP_MOV: res = b;
                        exec_pkg::OP_MVN: res = ~b;
                        exec_pkg::OP_AND: res = a & b;
                        exec_pkg::OP_ORR: res = a | b;
                        default:          res = a ^ b;
                    endcase
                end
            endcase
            if (row.set_flags || row.op == exec_pkg::OP_CMP) begin
                fl.n = res[31];
                fl.z = (res == 32'h0);
                fl.c = c;
                fl.v = arith ? v : fl.v;
            end
            if (row.op != exec_pkg::OP_CMP)
                regs[row.rd] = res;
            exp_data[i]  = res;
            exp_rd[i]    = row.rd;
            exp_wrote[i] = (row.op != exec_pkg::OP_CMP);
            exp_flags[i] = fl;
        end
    endtask

    task automatic check_result();
        int   i;
        logic bad;
        i   = res_idx;
        bad = 1'b0;
        if (i >= n_rows) begin
            $display("extra result for r%0d arrived after all rows were done, at %0t",
                     res_rd, $time);
            err_count++;
            return;
        end
        if (res_data !== exp_data[i]) begin
            $display("error at %0t: row %0d data %h, expected %h", $time, i, res_data, exp_data[i]);
            bad = 1'b1;
        end
        if (res_rd !== exp_rd[i]) begin
            $display("error at %0t: row %0d rd %0d, expected %0d", $time, i, res_rd, exp_rd[i]);
            bad = 1'b1;
        end
        if (res_wrote !== exp_wrote[i]) begin
            $display("error at %0t: row %0d wrote %b, expected %b", $time, i, res_wrote,
                     exp_wrote[i]);
            bad = 1'b1;
        end
        if (res_flags !== exp_flags[i]) begin
            $display("error at %0t: row %0d nzcv %b, expected %b", $time, i, res_flags,
                     exp_flags[i]);
            bad = 1'b1;
        end
        if (bad) begin
            err_count++;
            grp_errors++;
        end
        grp_results++;
        res_idx++;
        if (i == n_rows - 1 || tbl_group[i + 1] != tbl_group[i]) begin
            $display("group %0d %s: %0d results, %0d errors", tbl_group[i],
                     grp_name[tbl_group[i]], grp_results, grp_errors);
            grp_results = 0;
            grp_errors  = 0;
        end
    endtask

    // result handshake, in command order
    always @(posedge clk) begin
        if (!rst && res_valid && res_ready)
            check_result();
    end

    // back-pressure only in the random group
    initial begin
        res_ready = 1'b1;
        forever begin
            @(negedge clk);
            res_ready = random_ready ? ($urandom_range(0, 3) != 0) : 1'b1;
        end
    end

    initial begin
        wait (table_ready);
        repeat (RESET_CYCLES + n_rows * 20) @(posedge clk);
        $display("timeout: only %0d of %0d results arrived in time", res_idx, n_rows);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h54a5));
        rst          = 1'b1;
        cmd_valid    = 1'b0;
        cmd          = '0;
        random_ready = 1'b0;
        table_ready  = 1'b0;
        n_rows       = 0;
        res_idx      = 0;
        err_count    = 0;
        grp_results  = 0;
        grp_errors   = 0;
        grp_name = '{"mov", "data ops", "register shifts", "forwarding", "flags",
                     "random back-pressure"};
        build_table();
        run_model();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < n_rows; i++) begin
            random_ready = (tbl_group[i] == GRP_RANDOM);
            @(negedge clk);
            cmd       = tbl_cmd[i];
            cmd_valid = 1'b1;
            @(posedge clk);
            while (!cmd_ready)
                @(posedge clk);
        end
        @(negedge clk);
        cmd_valid = 1'b0;
        wait (res_idx == n_rows);
        // extra results would show up here
        repeat (20) @(posedge clk);
        $display("totals: %0d of %0d results checked, %0d errors", res_idx, n_rows, err_count);
        if (err_count == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== exec_top.sv ====
`timescale 1ns/100ps

module exec_top #(
    parameter int XLEN = 32
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              cmd_valid,
    input  exec_pkg::alu_op_t                 cmd_op,
    input  logic [exec_pkg::REG_ADDR_W-1:0]   cmd_rd,
    input  logic [exec_pkg::REG_ADDR_W-1:0]   cmd_rn,
    input  logic [exec_pkg::REG_ADDR_W-1:0]   cmd_rm,
    input  logic [exec_pkg::REG_ADDR_W-1:0]   cmd_rs,
    input  exec_pkg::shift_op_t               cmd_shift_op,
    input  logic [4:0]                        cmd_shift_imm,
    input  logic                              cmd_shift_by_reg,
    input  logic                              cmd_use_imm,
    input  logic [XLEN-1:0]                   cmd_imm,
    input  logic                              cmd_set_flags,
    output logic                              cmd_ready,
    output logic                              res_valid,
    output logic [XLEN-1:0]                   res_data,
    output logic [exec_pkg::REG_ADDR_W-1:0]   res_rd,
    output logic                              res_wrote,
    output exec_pkg::flags_t                  res_flags,
    input  logic                              res_ready
);

    exec_pkg::cmd_t    cmd_pkt;
    exec_pkg::result_t res_pkt;

    stage_if #(.payload_t(exec_pkg::cmd_t))    cmd_link ();
    stage_if #(.payload_t(exec_pkg::result_t)) res_link ();

    assign cmd_pkt.op           = cmd_op;
    assign cmd_pkt.rd           = cmd_rd;
    assign cmd_pkt.rn           = cmd_rn;
    assign cmd_pkt.rm           = cmd_rm;
    assign cmd_pkt.rs           = cmd_rs;
    assign cmd_pkt.shift_op     = cmd_shift_op;
    assign cmd_pkt.shift_imm    = cmd_shift_imm;
    assign cmd_pkt.shift_by_reg = cmd_shift_by_reg;
    assign cmd_pkt.use_imm      = cmd_use_imm;
    assign cmd_pkt.imm          = cmd_imm;
    assign cmd_pkt.set_flags    = cmd_set_flags;

    cmd_intake cmd_intake_i (
        .clk         (clk),
        .rst         (rst),
        .cmd_valid   (cmd_valid),
        .cmd_payload (cmd_pkt),
        .cmd_ready   (cmd_ready),
        .cmd_link    (cmd_link.src)
    );

    exec_datapath #(.XLEN(XLEN)) exec_datapath_i (
        .clk      (clk),
        .rst      (rst),
        .cmd_link (cmd_link.dst),
        .res_link (res_link.src)
    );

    result_out result_out_i (
        .clk         (clk),
        .rst         (rst),
        .res_link    (res_link.dst),
        .res_valid   (res_valid),
        .res_payload (res_pkt),
        .res_ready   (res_ready)
    );

    assign res_data  = res_pkt.data;
    assign res_rd    = res_pkt.rd;
    assign res_wrote = res_pkt.wrote;
    assign res_flags = res_pkt.flags;

endmodule

// ==== result_out.sv ====
`timescale 1ns/100ps

module result_out (
    input  logic                clk,
    input  logic                rst,
    stage_if.dst                res_link,
    output logic                res_valid,
    output exec_pkg::result_t   res_payload,
    input  logic                res_ready
);

    logic              full;
    exec_pkg::result_t held_res;
    logic              take;

    // room now, or the outside takes the held result at this edge
    assign res_link.ready = !full || res_ready;
    assign take = res_link.valid && res_link.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (take) begin
            full <= 1'b1;
        end else if (res_ready) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            held_res <= res_link.payload;
        end
    end

    assign res_valid   = full;
    assign res_payload = held_res;

endmodule

// ==== exec_datapath.sv ====
`timescale 1ns/100ps

module exec_datapath #(
    parameter int XLEN = 32
) (
    input  logic    clk,
    input  logic    rst,
    stage_if.dst    cmd_link,
    stage_if.src    res_link
);

    exec_pkg::cmd_t   ex_cmd;
    logic             ex_valid;
    logic [XLEN-1:0]  a_reg;
    logic [XLEN-1:0]  b_reg;
    logic [XLEN-1:0]  s_reg;
    exec_pkg::flags_t status_reg;
    exec_pkg::flags_t status_next;
    exec_pkg::flags_t alu_flags;
    logic [XLEN-1:0]  a_data;
    logic [XLEN-1:0]  b_data;
    logic [XLEN-1:0]  s_data;
    logic [XLEN-1:0]  a_in;
    logic [XLEN-1:0]  b_in;
    logic [XLEN-1:0]  s_in;
    logic [XLEN-1:0]  shift_out;
    logic             shift_carry;
    logic [XLEN-1:0]  alu_out;
    logic             ex_wrote;
    logic             ex_fire;
    logic             ex_free;
    logic             op_load;
    logic             fwd_a;
    logic             fwd_b;
    logic             fwd_s;
    logic             flag_upd;
    logic             is_arith;

    // stall control, all from the result side
    assign ex_wrote       = (ex_cmd.op != exec_pkg::OP_CMP);
    assign ex_fire        = ex_valid && res_link.ready;
    assign ex_free        = !ex_valid || res_link.ready;
    assign cmd_link.ready = ex_free;
    assign op_load        = cmd_link.valid && ex_free;

    regfile #(.XLEN(XLEN)) regfile_i (
        .clk    (clk),
        .rst    (rst),
        .w_en   (ex_fire && ex_wrote),
        .w_addr (ex_cmd.rd),
        .w_data (alu_out),
        .a_addr (cmd_link.payload.rn),
        .b_addr (cmd_link.payload.rm),
        .s_addr (cmd_link.payload.rs),
        .a_data (a_data),
        .b_data (b_data),
        .s_data (s_data)
    );

    // bypass the value being written at this same edge
    assign fwd_a = ex_valid && ex_wrote && (cmd_link.payload.rn == ex_cmd.rd);
    assign fwd_b = ex_valid && ex_wrote && (cmd_link.payload.rm == ex_cmd.rd);
    assign fwd_s = ex_valid && ex_wrote && (cmd_link.payload.rs == ex_cmd.rd);

    assign a_in = fwd_a ? alu_out : a_data;
    assign b_in = cmd_link.payload.use_imm ? cmd_link.payload.imm :
                  fwd_b ? alu_out : b_data;
    assign s_in = !cmd_link.payload.shift_by_reg ? XLEN'(cmd_link.payload.shift_imm) :
                  fwd_s ? alu_out : s_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else if (ex_free) begin
            ex_valid <= cmd_link.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (op_load) begin
            ex_cmd <= cmd_link.payload;
            a_reg  <= a_in;
            b_reg  <= b_in;
            s_reg  <= s_in;
        end
    end

    shifter #(.XLEN(XLEN)) shifter_i (
        .shift_in  (b_reg),
        .shift_op  (ex_cmd.shift_op),
        .shift_amt (s_reg),
        .shift_out (shift_out),
        .carry_out (shift_carry)
    );

    alu #(.XLEN(XLEN)) alu_i (
        .val_a       (a_reg),
        .val_b       (shift_out),
        .op          (ex_cmd.op),
        .shift_carry (shift_carry),
        .alu_out     (alu_out),
        .flags       (alu_flags)
    );

    // flags after this command
    assign flag_upd = ex_cmd.set_flags || (ex_cmd.op == exec_pkg::OP_CMP);
    assign is_arith = (ex_cmd.op == exec_pkg::OP_ADD) || (ex_cmd.op == exec_pkg::OP_SUB) ||
                      (ex_cmd.op == exec_pkg::OP_CMP);

    always_comb begin
        status_next = status_reg;
        if (flag_upd) begin
            status_next.n = alu_flags.n;
            status_next.z = alu_flags.z;
            status_next.c = alu_flags.c;
            if (is_arith) begin
                status_next.v = alu_flags.v;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            status_reg <= '0;
        end else if (ex_fire) begin
            status_reg <= status_next;
        end
    end

    assign res_link.valid         = ex_valid;
    assign res_link.payload.data  = alu_out;
    assign res_link.payload.rd    = ex_cmd.rd;
    assign res_link.payload.wrote = ex_wrote;
    assign res_link.payload.flags = status_next;

endmodule

// ==== alu.sv ====
`timescale 1ns/100ps

module alu #(
    parameter int XLEN = 32
) (
    input  logic [XLEN-1:0]       val_a,
    input  logic [XLEN-1:0]       val_b,
    input  exec_pkg::alu_op_t     op,
    input  logic                  shift_carry,
    output logic [XLEN-1:0]       alu_out,
    output exec_pkg::flags_t      flags
);

    logic            is_sub;
    logic            is_arith;
    logic [XLEN-1:0] b_eff;
    logic [XLEN:0]   sum;
    logic            overflow;

    assign is_sub   = (op == exec_pkg::OP_SUB) || (op == exec_pkg::OP_CMP);
    assign is_arith = is_sub || (op == exec_pkg::OP_ADD);

    // a - b as a + ~b + 1, so carry set means no borrow
    assign b_eff    = is_sub ? ~val_b : val_b;
    assign sum      = {1'b0, val_a} + {1'b0, b_eff} + {{XLEN{1'b0}}, is_sub};
    assign overflow = (val_a[XLEN-1] == b_eff[XLEN-1]) && (sum[XLEN-1] != val_a[XLEN-1]);

    always_comb begin
        case (op)
            exec_pkg::OP_MOV: alu_out = val_b;
            exec_pkg::OP_MVN: alu_out = ~val_b;
            exec_pkg::OP_AND: alu_out = val_a & val_b;
            exec_pkg::OP_ORR: alu_out = val_a | val_b;
            exec_pkg::OP_EOR: alu_out = val_a ^ val_b;
            default:          alu_out = sum[XLEN-1:0];
        endcase
    end

    assign flags.n = alu_out[XLEN-1];
    assign flags.z = (alu_out == '0);
    assign flags.c = is_arith ? sum[XLEN] : shift_carry;
    // logical ops keep the old V in the status register
    assign flags.v = is_arith ? overflow : 1'b0;

endmodule

// ==== shifter.sv ====
`timescale 1ns/100ps

module shifter #(
    parameter int XLEN = 32
) (
    input  logic [XLEN-1:0]       shift_in,
    input  exec_pkg::shift_op_t   shift_op,
    input  logic [XLEN-1:0]       shift_amt,
    output logic [XLEN-1:0]       shift_out,
    output logic                  carry_out
);

    localparam int AMT_W = $clog2(XLEN);

    logic [AMT_W-1:0] amt;
    logic [XLEN:0]    wide;

    // only the low bits of S count
    assign amt = shift_amt[AMT_W-1:0];

    // extra bit catches the last bit shifted out
    always_comb begin
        case (shift_op)
            exec_pkg::SH_LSL: wide = {1'b0, shift_in} << amt;
            exec_pkg::SH_LSR: wide = {shift_in, 1'b0} >> amt;
            exec_pkg::SH_ASR: wide = $signed({shift_in, 1'b0}) >>> amt;
            default: begin
                wide[XLEN:1] = (shift_in >> amt) | (shift_in << (XLEN - int'(amt)));
                wide[0]      = wide[XLEN];
            end
        endcase
    end

    assign shift_out = (shift_op == exec_pkg::SH_LSL) ? wide[XLEN-1:0] : wide[XLEN:1];
    // zero amount passes through with no carry
    assign carry_out = (amt == '0) ? 1'b0 :
                       (shift_op == exec_pkg::SH_LSL) ? wide[XLEN] : wide[0];

endmodule

// ==== regfile.sv ====
`timescale 1ns/100ps

module regfile #(
    parameter int XLEN = 32
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              w_en,
    input  logic [exec_pkg::REG_ADDR_W-1:0]   w_addr,
    input  logic [XLEN-1:0]                   w_data,
    input  logic [exec_pkg::REG_ADDR_W-1:0]   a_addr,
    input  logic [exec_pkg::REG_ADDR_W-1:0]   b_addr,
    input  logic [exec_pkg::REG_ADDR_W-1:0]   s_addr,
    output logic [XLEN-1:0]                   a_data,
    output logic [XLEN-1:0]                   b_data,
    output logic [XLEN-1:0]                   s_data
);

    localparam int NUM_REGS = 1 << exec_pkg::REG_ADDR_W;

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (w_en) begin
            regs[w_addr] <= w_data;
        end
    end

    // old value during a write, bypass lives in the datapath
    assign a_data = regs[a_addr];
    assign b_data = regs[b_addr];
    assign s_data = regs[s_addr];

endmodule

// ==== cmd_intake.sv ====
`timescale 1ns/100ps

module cmd_intake (
    input  logic              clk,
    input  logic              rst,
    input  logic              cmd_valid,
    input  exec_pkg::cmd_t    cmd_payload,
    output logic              cmd_ready,
    stage_if.src              cmd_link
);

    logic           full;
    exec_pkg::cmd_t held_cmd;
    exec_pkg::cmd_t norm_cmd;
    logic           take;

    // free now, or the held command leaves at this edge
    assign cmd_ready = !full || cmd_link.ready;
    assign take = cmd_valid && cmd_ready;

    // an immediate operand carries no shift
    always_comb begin
        norm_cmd = cmd_payload;
        if (cmd_payload.use_imm) begin
            norm_cmd.shift_by_reg = 1'b0;
            norm_cmd.shift_imm    = '0;
            norm_cmd.shift_op     = exec_pkg::SH_LSL;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (take) begin
            full <= 1'b1;
        end else if (cmd_link.ready) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            held_cmd <= norm_cmd;
        end
    end

    assign cmd_link.valid   = full;
    assign cmd_link.payload = held_cmd;

endmodule

// ==== stage_if.sv ====
`timescale 1ns/100ps

// valid/ready link between two stages
interface stage_if #(
    parameter type payload_t = logic
) ();

    logic     valid;
    logic     ready;
    payload_t payload;

    // sender side
    modport src (
        output valid,
        output payload,
        input  ready
    );

    // receiver side
    modport dst (
        input  valid,
        input  payload,
        output ready
    );

endinterface

// ==== exec_pkg.sv ====
package exec_pkg;

    localparam int REG_ADDR_W = 4;

    // data-processing opcodes
    typedef enum logic [2:0] {
        OP_MOV = 3'd0,
        OP_MVN = 3'd1,
        OP_ADD = 3'd2,
        OP_SUB = 3'd3,
        OP_AND = 3'd4,
        OP_ORR = 3'd5,
        OP_EOR = 3'd6,
        OP_CMP = 3'd7
    } alu_op_t;

    typedef enum logic [1:0] {
        SH_LSL = 2'd0,
        SH_LSR = 2'd1,
        SH_ASR = 2'd2,
        SH_ROR = 2'd3
    } shift_op_t;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flags_t;

    // one command, 32-bit data only
    typedef struct packed {
        alu_op_t                op;
        logic [REG_ADDR_W-1:0]  rd;
        logic [REG_ADDR_W-1:0]  rn;
        logic [REG_ADDR_W-1:0]  rm;
        logic [REG_ADDR_W-1:0]  rs;
        shift_op_t              shift_op;
        logic [4:0]             shift_imm;
        logic                   shift_by_reg;
        logic                   use_imm;
        logic [31:0]            imm;
        logic                   set_flags;
    } cmd_t;

    typedef struct packed {
        logic [31:0]            data;
        logic [REG_ADDR_W-1:0]  rd;
        logic                   wrote;
        flags_t                 flags;
    } result_t;

endpackage
